/* Makefile */
# Verilator build and run of the SPI master testbench

TOP := spi_controller_tb
BIN := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): src.f $(wildcard *.sv *.svh)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f src.f

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation finished: PASS"

clean:
	rm -rf obj_dir

/* byte_fifo.sv */
// Synchronous byte FIFO with occupancy count and flags.
// Head of the queue is visible on dout without a read latency.
`timescale 1ns/1ps
`default_nettype none

`include "spi_consts.svh"

module byte_fifo
(
    input  logic                    wb,
    input  logic                    reset,
    input  logic                    push,
    input  logic [7:0]              din,
    input  logic                    pop,
    output logic [7:0]              dout,
    output logic                    empty,
    output logic                    full,
    output logic [`SPI_COUNT_W-1:0] count
);

    localparam int ptr_w = $clog2(`SPI_FIFO_DEPTH);

    logic [7:0]       mem [`SPI_FIFO_DEPTH];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic             do_push;
    logic             do_pop;

    // Overflow and underflow requests are dropped
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign empty = (count == '0);
    assign full  = (count == `SPI_COUNT_W'(`SPI_FIFO_DEPTH));
    assign dout  = mem[rd_ptr];

    always_ff @(posedge wb)
    begin
        if (do_push)
        begin
            mem[wr_ptr] <= din;
        end
    end

    // Depth is a power of two, so the pointers wrap on their own
    always_ff @(posedge wb)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* spi_bus_pkg.sv */
// Types for the Wishbone register side of the SPI master.
// Imported by the register block and the top level.
`default_nettype none

package spi_bus_pkg;

`include "spi_consts.svh"

    // Wishbone slave state
    typedef enum logic {
        bus_idle,
        bus_reply
    } bus_state_e;

    // Result of the address decode
    typedef enum logic [2:0] {
        reg_data,
        reg_rxcount,
        reg_txcount,
        reg_conf,
        reg_csmask,
        reg_div,
        reg_none
    } reg_sel_e;

    // Configuration byte, DWS is kept but has no effect
    typedef struct packed {
        logic [7:`SPI_CONF_BLOCK+1] rsvd;
        logic                       block;
        logic                       cpol;
        logic                       cpha;
        logic                       dws;
        logic                       lsb;
    } spi_conf_t;

endpackage

`default_nettype wire

/* spi_consts.svh */
// Shared constants of the SPI master: register map, reset values and widths.
// Include wherever a register offset, a FIFO size or a bus width is needed.

`ifndef SPI_CONSTS_SVH
`define SPI_CONSTS_SVH

// Register offsets from the base address
`define SPI_ADDR_DATA     0
`define SPI_ADDR_RXCOUNT  4
`define SPI_ADDR_TXCOUNT  5
`define SPI_ADDR_CONF     6
`define SPI_ADDR_CSMASK   7
`define SPI_ADDR_DIV      8

// FIFO sizing, count must hold 0..depth
`define SPI_FIFO_DEPTH    16
`define SPI_COUNT_W       5

// Wishbone widths
`define SPI_ADR_W         8
`define SPI_DAT_W         32

// Reset values
`define SPI_CONF_RESET    0
`define SPI_DIV_RESET     7

// Configuration bit positions
`define SPI_CONF_LSB      0
`define SPI_CONF_DWS      1
`define SPI_CONF_CPHA     2
`define SPI_CONF_CPOL     3
`define SPI_CONF_BLOCK    4

`endif

/* spi_controller.sv */
// Top level of the Wishbone SPI master.
// Connects the register block, the transmit and receive FIFOs and the shifter.
`timescale 1ns/1ps
`default_nettype none

`include "spi_consts.svh"

module spi_controller
    import spi_bus_pkg::*;
    import spi_line_pkg::*;
#(
    parameter int base_addr = 0
)
(
    input  logic                  wb,
    input  logic                  reset,
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  logic [`SPI_ADR_W-1:0] wb_adr,
    input  logic [`SPI_DAT_W-1:0] wb_dat_w,
    output logic [`SPI_DAT_W-1:0] wb_dat_r,
    output logic                  wb_ack,
    output logic                  wb_err,
    output logic                  sclk,
    output logic                  mosi,
    input  logic                  miso,
    output logic [7:0]            cs
);

    spi_conf_t               conf;
    logic [7:0]              cs_mask;
    logic [7:0]              div;
    logic                    tx_push;
    logic                    tx_ready;
    logic                    tx_empty;
    logic                    tx_full;
    logic [7:0]              tx_byte;
    logic [`SPI_COUNT_W-1:0] tx_count;
    logic                    rx_pop;
    logic                    rx_valid;
    logic                    rx_empty;
    logic                    rx_full;
    logic [7:0]              rx_byte;
    logic [7:0]              rx_head;
    logic [`SPI_COUNT_W-1:0] rx_count;

    spi_regs #(.base_addr(base_addr)) regs_i (
        .wb(wb), .reset(reset), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r),
        .wb_ack(wb_ack), .wb_err(wb_err),
        .tx_push(tx_push), .tx_full(tx_full), .tx_count(tx_count),
        .rx_pop(rx_pop), .rx_empty(rx_empty), .rx_full(rx_full),
        .rx_count(rx_count), .rx_head(rx_head),
        .conf(conf), .cs_mask(cs_mask), .div(div)
    );

    // Bus writes carry the byte in the low lane
    byte_fifo tx_fifo_i (
        .wb(wb), .reset(reset), .push(tx_push), .din(wb_dat_w[7:0]), .pop(tx_ready),
        .dout(tx_byte), .empty(tx_empty), .full(tx_full), .count(tx_count)
    );

    byte_fifo rx_fifo_i (
        .wb(wb), .reset(reset), .push(rx_valid), .din(rx_byte), .pop(rx_pop),
        .dout(rx_head), .empty(rx_empty), .full(rx_full), .count(rx_count)
    );

    spi_shifter shifter_i (
        .wb(wb), .reset(reset), .mode(spi_mode_t'({conf.cpol, conf.cpha})),
        .lsb_first(conf.lsb), .block(conf.block), .div(div), .cs_mask(cs_mask),
        .tx_valid(!tx_empty), .tx_ready(tx_ready), .tx_byte(tx_byte),
        .rx_space(!rx_full), .rx_valid(rx_valid), .rx_byte(rx_byte),
        .sclk(sclk), .mosi(mosi), .miso(miso), .cs(cs)
    );

endmodule

`default_nettype wire

/* spi_controller_props.sv */
// Bus and line invariants of the SPI master.
// Bound to every spi_controller instance by the bind at the end of this file.
`timescale 1ns/1ps
`default_nettype none

module spi_controller_props
    import spi_bus_pkg::*;
(
    input logic       wb,
    input logic       reset,
    input logic       wb_cyc,
    input logic       wb_stb,
    input logic       wb_ack,
    input logic       wb_err,
    input logic [7:0] cs,
    input logic [7:0] cs_mask,
    input logic       sclk,
    input spi_conf_t  conf
);

    // One kind of reply at a time
    ack_err_excl: assert property (@(posedge wb) disable iff (reset)
        !(wb_ack && wb_err))
        else $error("ack and err are high together");

    reply_in_cycle: assert property (@(posedge wb) disable iff (reset)
        (wb_ack || wb_err) |-> (wb_stb && wb_cyc))
        else $error("reply outside of a strobed bus cycle");

    cs_is_mask: assert property (@(posedge wb) disable iff (reset)
        (cs == 8'h00) || (cs == cs_mask))
        else $error("chip select differs from the mask register");

    // Idle clock level
    sclk_idle: assert property (@(posedge wb) disable iff (reset)
        (cs == 8'h00) |-> (sclk == conf.cpol))
        else $error("sclk is not at CPOL while no chip is selected");

endmodule

bind spi_controller spi_controller_props props_i (
    .wb(wb), .reset(reset), .wb_cyc(wb_cyc), .wb_stb(wb_stb),
    .wb_ack(wb_ack), .wb_err(wb_err), .cs(cs), .cs_mask(cs_mask),
    .sclk(sclk), .conf(conf)
);

`default_nettype wire

/* spi_controller_tb.sv */
// Directed tests of the Wishbone SPI master with MOSI looped back to MISO.
// Prints one line per test and a closing summary.
`timescale 1ns/1ps
`default_nettype none

`include "spi_consts.svh"

module spi_controller_tb;

    localparam int bus_limit   = 50;
    localparam int poll_limit  = 2000;
    localparam int cycle_limit = 400;

    logic                  wb;
    logic                  reset;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_we;
    logic [`SPI_ADR_W-1:0] wb_adr;
    logic [`SPI_DAT_W-1:0] wb_dat_w;
    logic [`SPI_DAT_W-1:0] wb_dat_r;
    logic                  wb_ack;
    logic                  wb_err;
    logic                  sclk;
    logic                  mosi;
    logic [7:0]            cs;

    int         errors = 0;
    int         checks = 0;
    int         tests = 0;
    logic [7:0] mask_exp;
    logic       cpol_exp;
    bit         watch_lines = 1'b0;
    int         frame_cycles;
    bit         record_bits = 1'b0;
    logic       mosi_bits[$];

    tb_clock clock_i (.wb(wb), .reset(reset));

    spi_controller dut_i (
        .wb(wb), .reset(reset), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r),
        .wb_ack(wb_ack), .wb_err(wb_err),
        .sclk(sclk), .mosi(mosi), .miso(mosi), .cs(cs)
    );

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("MISMATCH at %0t: %s got 0x%0h, expected 0x%0h", $time, what, got, exp);
        end
    endtask

    task automatic finish_test(input string name, input int errs_at_start);
        tests++;
        $display("%-14s %s, %0d errors", name,
                 (errors == errs_at_start) ? "ok" : "failed", errors - errs_at_start);
    endtask

    ////////////////////////////////////////
    // Bus access
    ////////////////////////////////////////
    task automatic bus_write(input int addr, input int data, output logic err);
        int waited;
        waited   = 0;
        err      = 1'b1;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = `SPI_ADR_W'(addr);
        wb_dat_w = `SPI_DAT_W'(data);
        do
        begin
            @(negedge wb);
            waited++;
        end
        while (!wb_ack && !wb_err && waited < bus_limit);
        if (wb_ack || wb_err)
            err = wb_err;
        else
        begin
            errors++;
            $display("ERROR: bus write to 0x%0h got no reply", addr);
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic bus_read(input int addr, output logic [31:0] data, output logic err);
        int waited;
        waited = 0;
        data   = '0;
        err    = 1'b1;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = `SPI_ADR_W'(addr);
        do
        begin
            @(negedge wb);
            waited++;
        end
        while (!wb_ack && !wb_err && waited < bus_limit);
        if (wb_ack || wb_err)
        begin
            err  = wb_err;
            data = wb_dat_r;
        end
        else
        begin
            errors++;
            $display("ERROR: bus read from 0x%0h got no reply", addr);
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    task automatic write_expect(input string what, input int addr, input int data,
                                input logic exp_err);
        logic err;
        bus_write(addr, data, err);
        check_value({what, " err flag"}, 32'(err), 32'(exp_err));
    endtask

    // Data is only compared on an accepted read
    task automatic read_expect(input string what, input int addr, input logic exp_err,
                               input int exp);
        logic [31:0] rdata;
        logic        err;
        bus_read(addr, rdata, err);
        check_value({what, " err flag"}, 32'(err), 32'(exp_err));
        if (!exp_err)
            check_value(what, rdata, exp);
    endtask

    task automatic wait_count(input int addr, input int target);
        logic [31:0] rdata;
        logic        err;
        int          polls;
        polls = 0;
        do
        begin
            bus_read(addr, rdata, err);
            polls++;
        end
        while (rdata != 32'(target) && polls < poll_limit);
        if (rdata != 32'(target))
        begin
            errors++;
            $display("ERROR: count at 0x%0h did not reach %0d", addr, target);
        end
    endtask

    task automatic wait_frame_end();
        int waited;
        waited = 0;
        while (cs != 8'h00 && waited < cycle_limit)
        begin
            @(negedge wb);
            waited++;
        end
        if (cs != 8'h00)
        begin
            errors++;
            $display("ERROR: chip select stayed active, frame never ended");
        end
    endtask

    // Line checks while a loopback frame is in flight
    always @(negedge wb)
    begin
        if (watch_lines)
        begin
            if (cs != 8'h00)
            begin
                frame_cycles++;
                check_value("cs during frame", 32'(cs), 32'(mask_exp));
            end
            else
                check_value("sclk between frames", 32'(sclk), 32'(cpol_exp));
        end
    end

    always @(posedge sclk)
    begin
        if (record_bits && cs != 8'h00)
            mosi_bits.push_back(mosi);
    end

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////
    task automatic reset_test();
        int start;
        start = errors;
        read_expect("conf after reset", `SPI_ADDR_CONF, 1'b0, 0);
        read_expect("mask after reset", `SPI_ADDR_CSMASK, 1'b0, 0);
        read_expect("div after reset", `SPI_ADDR_DIV, 1'b0, 7);
        read_expect("rx count after reset", `SPI_ADDR_RXCOUNT, 1'b0, 0);
        read_expect("tx count after reset", `SPI_ADDR_TXCOUNT, 1'b0, 0);
        check_value("cs after reset", 32'(cs), 0);
        check_value("sclk after reset", 32'(sclk), 0);
        finish_test("reset state", start);
    endtask

    task automatic register_test();
        int start;
        start = errors;
        // Reserved and DWS bits read back as written
        write_expect("conf write", `SPI_ADDR_CONF, 8'ha7, 1'b0);
        read_expect("conf readback", `SPI_ADDR_CONF, 1'b0, 8'ha7);
        write_expect("mask write", `SPI_ADDR_CSMASK, 8'h3c, 1'b0);
        read_expect("mask readback", `SPI_ADDR_CSMASK, 1'b0, 8'h3c);
        write_expect("div write", `SPI_ADDR_DIV, 8'h21, 1'b0);
        read_expect("div readback", `SPI_ADDR_DIV, 1'b0, 8'h21);
        write_expect("write past div", `SPI_ADDR_DIV + 1, 8'h11, 1'b1);
        read_expect("read past div", `SPI_ADDR_DIV + 1, 1'b1, 0);
        read_expect("read top address", 8'hff, 1'b1, 0);
        read_expect("read empty rx fifo", `SPI_ADDR_DATA, 1'b1, 0);
        write_expect("conf clear", `SPI_ADDR_CONF, 8'h00, 1'b0);
        finish_test("registers", start);
    endtask

    task automatic loopback_test();
        int         start;
        logic [7:0] sent;
        start = errors;
        write_expect("div write", `SPI_ADDR_DIV, 2, 1'b0);
        for (int m = 0; m < 4; m++)
        begin
            for (int lsb = 0; lsb < 2; lsb++)
            begin
                mask_exp = 8'h01 << (2 * m + lsb);
                cpol_exp = m[1];
                write_expect("mode conf", `SPI_ADDR_CONF, {4'h0, m[1], m[0], 1'b0, lsb[0]}, 1'b0);
                write_expect("mask write", `SPI_ADDR_CSMASK, mask_exp, 1'b0);
                frame_cycles = 0;
                watch_lines  = 1'b1;
                sent = 8'($urandom);
                write_expect("data write", `SPI_ADDR_DATA, sent, 1'b0);
                wait_count(`SPI_ADDR_RXCOUNT, 1);
                watch_lines = 1'b0;
                check_value("frame with cs seen", 32'(frame_cycles > 0), 1);
                read_expect($sformatf("loopback mode %0d lsb %0d", m, lsb),
                            `SPI_ADDR_DATA, 1'b0, sent);
            end
        end
        finish_test("loopback", start);
    endtask

    task automatic bit_order_test();
        int         start;
        logic [7:0] sent;
        start = errors;
        write_expect("div write", `SPI_ADDR_DIV, 3, 1'b0);
        write_expect("mask write", `SPI_ADDR_CSMASK, 8'h80, 1'b0);
        for (int lsb = 0; lsb < 2; lsb++)
        begin
            write_expect("mode 0 conf", `SPI_ADDR_CONF, {7'h00, lsb[0]}, 1'b0);
            sent = 8'($urandom);
            mosi_bits.delete();
            record_bits = 1'b1;
            write_expect("data write", `SPI_ADDR_DATA, sent, 1'b0);
            wait_count(`SPI_ADDR_RXCOUNT, 1);
            record_bits = 1'b0;
            check_value("rising sclk edges", mosi_bits.size(), 8);
            for (int i = 0; i < 8 && i < mosi_bits.size(); i++)
                check_value($sformatf("mosi bit %0d lsb %0d", i, lsb), 32'(mosi_bits[i]),
                            32'(lsb ? sent[i] : sent[7 - i]));
            read_expect("bit order byte", `SPI_ADDR_DATA, 1'b0, sent);
        end
        finish_test("bit order", start);
    endtask

    task automatic block_test();
        int         start;
        logic [7:0] sent_q[$];
        logic [7:0] b;
        start = errors;
        write_expect("div write", `SPI_ADDR_DIV, 0, 1'b0);
        write_expect("mask write", `SPI_ADDR_CSMASK, 8'h01, 1'b0);
        write_expect("block on", `SPI_ADDR_CONF, 8'h10, 1'b0);
        for (int i = 0; i < `SPI_FIFO_DEPTH; i++)
        begin
            b = 8'($urandom);
            sent_q.push_back(b);
            write_expect("fill write", `SPI_ADDR_DATA, b, 1'b0);
            wait_count(`SPI_ADDR_RXCOUNT, i + 1);
        end
        read_expect("rx count full", `SPI_ADDR_RXCOUNT, 1'b0, 16);
        write_expect("write with rx full", `SPI_ADDR_DATA, 8'h5a, 1'b1);
        read_expect("tx count refused", `SPI_ADDR_TXCOUNT, 1'b0, 0);
        // Without block the extra byte goes out and is lost
        write_expect("block off", `SPI_ADDR_CONF, 8'h00, 1'b0);
        write_expect("extra write", `SPI_ADDR_DATA, 8'hc3, 1'b0);
        wait_count(`SPI_ADDR_TXCOUNT, 0);
        wait_frame_end();
        read_expect("rx count after drop", `SPI_ADDR_RXCOUNT, 1'b0, 16);
        for (int i = 0; i < `SPI_FIFO_DEPTH; i++)
            read_expect($sformatf("rx byte %0d", i), `SPI_ADDR_DATA, 1'b0, sent_q[i]);
        finish_test("blocking", start);
    endtask

    initial
    begin
        int waited;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        void'($urandom(32'h57b9_f702));
        waited = 0;
        while (reset !== 1'b0 && waited < 20)
        begin
            @(negedge wb);
            waited++;
        end
        if (reset !== 1'b0)
        begin
            errors++;
            $display("ERROR: reset was never released");
        end
        reset_test();
        register_test();
        loopback_test();
        bit_order_test();
        block_test();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* spi_line_pkg.sv */
// Types for the SPI serial engine.
`default_nettype none

package spi_line_pkg;

`include "spi_consts.svh"

    // Serial engine phases of one frame
    typedef enum logic [1:0] {
        sh_idle,
        sh_lead,
        sh_shift,
        sh_trail
    } shift_state_e;

    // SPI mode as clock polarity and phase
    typedef struct packed {
        logic cpol;
        logic cpha;
    } spi_mode_t;

endpackage

`default_nettype wire

/* spi_regs.sv */
// Wishbone slave of the SPI master with its register file.
// Decodes the register window, pushes and pops the FIFOs, replies ack or err.
`timescale 1ns/1ps
`default_nettype none

`include "spi_consts.svh"

module spi_regs
    import spi_bus_pkg::*;
#(
    parameter int base_addr = 0
)
(
    input  logic                    wb,
    input  logic                    reset,
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  logic [`SPI_ADR_W-1:0]   wb_adr,
    input  logic [`SPI_DAT_W-1:0]   wb_dat_w,
    output logic [`SPI_DAT_W-1:0]   wb_dat_r,
    output logic                    wb_ack,
    output logic                    wb_err,
    output logic                    tx_push,
    input  logic                    tx_full,
    input  logic [`SPI_COUNT_W-1:0] tx_count,
    output logic                    rx_pop,
    input  logic                    rx_empty,
    input  logic                    rx_full,
    input  logic [`SPI_COUNT_W-1:0] rx_count,
    input  logic [7:0]              rx_head,
    output spi_conf_t               conf,
    output logic [7:0]              cs_mask,
    output logic [7:0]              div
);

    bus_state_e            state;
    reg_sel_e              sel;
    logic [`SPI_ADR_W-1:0] offset;
    logic                  req;
    logic                  stall;
    logic                  reply_err;
    logic                  ack_q;
    logic                  err_q;

    ////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////
    always_comb
    begin
        offset = wb_adr - `SPI_ADR_W'(base_addr);
        sel    = reg_none;
        if (wb_adr >= `SPI_ADR_W'(base_addr))
        begin
            case (offset)
                `SPI_ADR_W'(`SPI_ADDR_DATA):    sel = reg_data;
                `SPI_ADR_W'(`SPI_ADDR_RXCOUNT): sel = reg_rxcount;
                `SPI_ADR_W'(`SPI_ADDR_TXCOUNT): sel = reg_txcount;
                `SPI_ADR_W'(`SPI_ADDR_CONF):    sel = reg_conf;
                `SPI_ADR_W'(`SPI_ADDR_CSMASK):  sel = reg_csmask;
                `SPI_ADR_W'(`SPI_ADDR_DIV):     sel = reg_div;
                default:                        sel = reg_none;
            endcase
        end
    end

    // Decide the reply of the pending request
    always_comb
    begin
        req       = wb_cyc && wb_stb && (state == bus_idle);
        stall     = 1'b0;
        reply_err = 1'b0;
        case (sel)
            reg_none: reply_err = 1'b1;
            reg_data:
            begin
                if (wb_we)
                begin
                    // Block mode refuses data that could be lost
                    if (conf.block && (tx_full || rx_full))
                        reply_err = 1'b1;
                    else if (tx_full)
                        stall = 1'b1;
                end
                else if (rx_empty)
                begin
                    reply_err = 1'b1;
                end
            end
            default: reply_err = 1'b0;
        endcase
    end

    // Byte enters the transmit FIFO on the deciding edge
    assign tx_push = req && wb_we && (sel == reg_data) && !stall && !reply_err;

    ////////////////////////////////////////
    // Bus state and registers
    ////////////////////////////////////////
    always_ff @(posedge wb)
    begin
        if (reset)
        begin
            state   <= bus_idle;
            ack_q   <= 1'b0;
            err_q   <= 1'b0;
            rx_pop  <= 1'b0;
            conf    <= spi_conf_t'(8'(`SPI_CONF_RESET));
            cs_mask <= '0;
            div     <= 8'(`SPI_DIV_RESET);
        end
        else
        begin
            ack_q  <= 1'b0;
            err_q  <= 1'b0;
            rx_pop <= 1'b0;
            case (state)
                bus_idle:
                begin
                    if (req && !stall)
                    begin
                        state  <= bus_reply;
                        ack_q  <= !reply_err;
                        err_q  <= reply_err;
                        // Pop lands at the end of the reply cycle
                        rx_pop <= !wb_we && (sel == reg_data) && !reply_err;
                        if (wb_we && !reply_err)
                        begin
                            case (sel)
                                reg_conf:   conf    <= wb_dat_w[7:0];
                                reg_csmask: cs_mask <= wb_dat_w[7:0];
                                reg_div:    div     <= wb_dat_w[7:0];
                                default:    ;
                            endcase
                        end
                    end
                end
                default: state <= bus_idle;
            endcase
        end
    end

    // Read data follows the address, zero-extended
    always_comb
    begin
        wb_dat_r = '0;
        case (sel)
            reg_data:    wb_dat_r[7:0] = rx_head;
            reg_rxcount: wb_dat_r[`SPI_COUNT_W-1:0] = rx_count;
            reg_txcount: wb_dat_r[`SPI_COUNT_W-1:0] = tx_count;
            reg_conf:    wb_dat_r[7:0] = conf;
            reg_csmask:  wb_dat_r[7:0] = cs_mask;
            reg_div:     wb_dat_r[7:0] = div;
            default:     wb_dat_r = '0;
        endcase
    end

    assign wb_ack = ack_q && wb_stb && wb_cyc;
    assign wb_err = err_q && wb_stb && wb_cyc;

endmodule

`default_nettype wire

/* spi_shifter.sv */
// SPI serial engine: paces SCLK from the divider, drives MOSI and samples MISO.
// Takes one byte per frame from the transmit FIFO and returns the received byte.
`timescale 1ns/1ps
`default_nettype none

module spi_shifter
    import spi_line_pkg::*;
(
    input  logic       wb,
    input  logic       reset,
    input  spi_mode_t  mode,
    input  logic       lsb_first,
    input  logic       block,
    input  logic [7:0] div,
    input  logic [7:0] cs_mask,
    input  logic       tx_valid,
    output logic       tx_ready,
    input  logic [7:0] tx_byte,
    input  logic       rx_space,
    output logic       rx_valid,
    output logic [7:0] rx_byte,
    output logic       sclk,
    output logic       mosi,
    input  logic       miso,
    output logic [7:0] cs
);

    shift_state_e state;
    spi_mode_t    mode_q;
    logic         lsb_q;
    logic [7:0]   div_q;
    logic [7:0]   hcnt;
    logic [3:0]   hidx;
    logic [3:0]   next_idx;
    logic [7:0]   tx_sr;
    logic         half_done;
    logic         enter_half;
    logic         sample;
    logic         shift;

    assign half_done = (hcnt == div_q);

    // Hold off while the previous byte is still on its way to the FIFO
    assign tx_ready = (state == sh_idle) && tx_valid && !rx_valid && (rx_space || !block);

    ////////////////////////////////////////
    // Edge events
    ////////////////////////////////////////
    // Even shift halves start with the leading SCLK edge, odd ones with the
    // trailing edge. CPHA 0 samples on leading edges and shifts on trailing
    // ones, CPHA 1 the other way round.
    always_comb
    begin
        next_idx   = (state == sh_lead) ? 4'd0 : hidx + 4'd1;
        enter_half = half_done &&
                     ((state == sh_lead) || ((state == sh_shift) && (hidx != 4'd15)));
        sample     = enter_half && (next_idx[0] == mode_q.cpha);
        // First bit is already on MOSI when the frame starts
        shift      = enter_half && (next_idx[0] != mode_q.cpha) && (next_idx != 4'd0);
    end

    ////////////////////////////////////////
    // Frame FSM and transmit shifter
    ////////////////////////////////////////
    always_ff @(posedge wb)
    begin
        if (reset)
        begin
            state    <= sh_idle;
            mode_q   <= '0;
            lsb_q    <= 1'b0;
            div_q    <= '0;
            hcnt     <= '0;
            hidx     <= '0;
            tx_sr    <= '0;
            rx_valid <= 1'b0;
        end
        else
        begin
            rx_valid <= 1'b0;
            if ((state == sh_idle) || half_done)
                hcnt <= '0;
            else
                hcnt <= hcnt + 8'd1;

            case (state)
                sh_idle:
                begin
                    if (tx_ready)
                    begin
                        // Settings stay fixed for the whole frame
                        state  <= sh_lead;
                        mode_q <= mode;
                        lsb_q  <= lsb_first;
                        div_q  <= div;
                        tx_sr  <= tx_byte;
                    end
                end
                sh_lead:
                begin
                    if (half_done)
                    begin
                        state <= sh_shift;
                        hidx  <= '0;
                    end
                end
                sh_shift:
                begin
                    if (half_done)
                    begin
                        if (hidx == 4'd15)
                            state <= sh_trail;
                        else
                            hidx <= next_idx;
                    end
                end
                default:
                begin
                    if (half_done)
                    begin
                        state    <= sh_idle;
                        rx_valid <= 1'b1;
                    end
                end
            endcase

            if (shift)
                tx_sr <= lsb_q ? {1'b0, tx_sr[7:1]} : {tx_sr[6:0], 1'b0};
        end
    end

    // Receive assembly mirrors the transmit order
    always_ff @(posedge wb)
    begin
        if (sample)
            rx_byte <= lsb_q ? {miso, rx_byte[7:1]} : {rx_byte[6:0], miso};
    end

    assign mosi = lsb_q ? tx_sr[0] : tx_sr[7];
    assign cs   = (state == sh_idle) ? 8'h00 : cs_mask;

    // Idle level follows the live CPOL
    always_comb
    begin
        case (state)
            sh_idle:  sclk = mode.cpol;
            sh_shift: sclk = mode_q.cpol ^ ~hidx[0];
            default:  sclk = mode_q.cpol;
        endcase
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+.
spi_bus_pkg.sv
spi_line_pkg.sv
byte_fifo.sv
spi_regs.sv
spi_shifter.sv
spi_controller.sv
tb_clock.sv
spi_controller_props.sv
spi_controller_tb.sv

/* tb_clock.sv */
// Clock and reset source for the SPI master testbench.
// 10 ns clock, reset high for the first two cycles.
`timescale 1ns/1ps
`default_nettype none

module tb_clock
(
    output logic wb,
    output logic reset
);

    initial
    begin
        wb    = 1'b0;
        reset = 1'b1;
        forever #5 wb = ~wb;
    end

    // Release on a falling edge like every other input
    initial
    begin
        repeat (2) @(posedge wb);
        @(negedge wb);
        reset = 1'b0;
    end

endmodule

`default_nettype wire
